/* src/mem_map_defines.svh */
// Bank word addresses are 22 bits wide; offsets must leave room for each client's full range
`ifndef MEM_MAP_DEFINES_SVH
`define MEM_MAP_DEFINES_SVH

// Word address width of the shared SDRAM bank
`define MEM_AW 22

// Bank base of each client region, in words
`define RAM_OFFSET 22'h10_0000
`define ROM_OFFSET 22'h00_0000
`define GFX_OFFSET 22'h20_0000

// Blanking cycles between two refresh requests
`define REFRESH_INTERVAL 16

`endif

/* src/mem_map_pkg.sv */
// Types shared by the slots and the arbiter; request fields are levels held until grant_rdy
`default_nettype none
`include "mem_map_defines.svh"

package mem_map_pkg;

    // One bank access as raised by a slot
    typedef struct packed {
        logic [`MEM_AW-1:0] addr;  // Bank word address, offset included
        logic               rd;
        logic               wr;
        logic [15:0]        din;
        logic [1:0]         mask;  // Active low byte mask
    } bank_req_t;

    // Also the bit index into the grant vectors
    typedef enum logic [1:0] {
        SLOT_RAM = 2'd0,
        SLOT_ROM = 2'd1,
        SLOT_GFX = 2'd2
    } slot_id_t;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        REQ      = 2'd1,  // rd or wr on the bank, waiting for ack
        WAIT_RDY = 2'd2,
        REFRESH  = 2'd3
    } arb_state_t;

endpackage

`default_nettype wire

/* src/mem_slot.sv */
// Client must hold cs, addr and write data until ok; payload must be 16 or 32 bits
`timescale 1ns/100ps
`default_nettype none
`include "mem_map_defines.svh"

module mem_slot #(
    parameter type payload_t = logic [15:0],
    parameter int  AW        = 16
) (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       cs,
    input  wire [AW-1:0]              addr,
    input  wire [`MEM_AW-1:0]         offset,
    input  wire                       wen,
    input  wire [15:0]                din,
    input  wire [1:0]                 wrmask,  // Active low
    input  wire                       grant_ack,
    input  wire                       grant_rdy,
    input  wire [31:0]                data_read,
    output payload_t                  dout,
    output logic                      ok,
    output mem_map_pkg::bank_req_t    req
);

    localparam int MAW = `MEM_AW;
    localparam int PW  = $bits(payload_t);

    logic           valid;
    logic [AW-1:0]  tag;
    payload_t       cached;
    payload_t       merged;
    logic           wr_done;
    logic           pend_rd;
    logic           pend_wr;
    logic [MAW-1:0] pend_addr;
    logic [15:0]    pend_din;
    logic [1:0]     pend_mask;
    logic           hit;
    logic           idle;
    logic           launch_rd;
    logic           launch_wr;

    assign hit       = valid && tag == addr;
    assign idle      = !pend_rd && !pend_wr;
    assign launch_rd = cs && !wen && !hit && idle;
    assign launch_wr = cs && wen && !wr_done && idle;

    // Writes report ok only once the bank has taken them
    assign ok   = cs && (wen ? wr_done : hit);
    assign dout = cached;

    always_comb begin
        req.addr = pend_addr;
        req.rd   = pend_rd;
        req.wr   = pend_wr;
        req.din  = pend_din;
        req.mask = pend_mask;
    end

    // Bytes with a low mask bit come from the client
    always_comb begin
        merged = cached;
        if (!wrmask[0]) merged[7:0]  = din[7:0];
        if (!wrmask[1]) merged[15:8] = din[15:8];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_rd <= 1'b0;
            pend_wr <= 1'b0;
            valid   <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            if (grant_rdy) begin
                pend_rd <= 1'b0;
                pend_wr <= 1'b0;
                if (pend_rd) valid <= 1'b1;
                if (pend_wr) wr_done <= 1'b1;
            end else if (launch_rd) begin
                pend_rd <= 1'b1;
                valid   <= 1'b0;  // Tag moves to the new address
            end else if (launch_wr) begin
                pend_wr <= 1'b1;
            end
            if (!cs) wr_done <= 1'b0;  // Next write needs a fresh cs
        end
    end

    always_ff @(posedge clk) begin
        if (launch_rd || launch_wr) begin
            pend_addr <= offset + MAW'(addr);
            pend_din  <= din;
            pend_mask <= wrmask;
        end
        if (launch_rd) tag <= addr;
        if (grant_rdy && pend_rd) cached <= data_read[PW-1:0];
        if (grant_rdy && pend_wr && hit) cached <= merged;  // Keep cached word coherent
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n) !(req.rd && req.wr))
        else $error("mem_slot: read and write raised together");

    // Arbiter only acknowledges a slot that is asking
    a_ack_pending: assert property (@(posedge clk) disable iff (!arst_n)
        grant_ack |-> (pend_rd || pend_wr))
        else $error("mem_slot: grant_ack without a pending request");

endmodule

`default_nettype wire

/* src/bank_arbiter.sv */
// One bank access at a time; the bank must pulse ack before rdy and refresh wins over all slots
`timescale 1ns/100ps
`default_nettype none
`include "mem_map_defines.svh"

module bank_arbiter (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire mem_map_pkg::bank_req_t ram_req,
    input  wire mem_map_pkg::bank_req_t rom_req,
    input  wire mem_map_pkg::bank_req_t gfx_req,
    input  wire                       refresh_req,
    input  wire                       bank_ack,
    input  wire                       bank_rdy,
    output logic [2:0]                grant_ack,
    output logic [2:0]                grant_rdy,
    output logic                      refresh_done,
    output logic                      refresh_en,
    output logic [`MEM_AW-1:0]        bank_addr,
    output logic                      bank_rd,
    output logic                      bank_wr,
    output logic [15:0]               bank_din,
    output logic [1:0]                bank_mask
);

    mem_map_pkg::arb_state_t state;
    mem_map_pkg::slot_id_t   slot;   // Slot being served
    mem_map_pkg::bank_req_t  sel;
    logic                    ram_pend;
    logic                    rom_pend;
    logic                    gfx_pend;

    assign ram_pend = ram_req.rd || ram_req.wr;
    assign rom_pend = rom_req.rd || rom_req.wr;
    assign gfx_pend = gfx_req.rd || gfx_req.wr;

    always_comb begin
        case (slot)
            mem_map_pkg::SLOT_RAM: sel = ram_req;
            mem_map_pkg::SLOT_ROM: sel = rom_req;
            default:               sel = gfx_req;
        endcase
    end

    // Strobes only in REQ and the payload follows the latched slot
    assign bank_rd   = state == mem_map_pkg::REQ && sel.rd;
    assign bank_wr   = state == mem_map_pkg::REQ && sel.wr;
    assign bank_addr = sel.addr;
    assign bank_din  = sel.din;
    assign bank_mask = sel.mask;

    assign refresh_en   = state == mem_map_pkg::REFRESH;
    assign refresh_done = state == mem_map_pkg::REFRESH;

    always_comb begin
        grant_ack = 3'b000;
        grant_rdy = 3'b000;
        grant_ack[slot] = state == mem_map_pkg::REQ && bank_ack;
        grant_rdy[slot] = state == mem_map_pkg::WAIT_RDY && bank_rdy;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= mem_map_pkg::IDLE;
            slot  <= mem_map_pkg::SLOT_RAM;
        end else begin
            case (state)
                mem_map_pkg::IDLE: begin
                    if (refresh_req) begin
                        state <= mem_map_pkg::REFRESH;
                    end else if (ram_pend) begin
                        slot  <= mem_map_pkg::SLOT_RAM;
                        state <= mem_map_pkg::REQ;
                    end else if (rom_pend) begin
                        slot  <= mem_map_pkg::SLOT_ROM;
                        state <= mem_map_pkg::REQ;
                    end else if (gfx_pend) begin
                        slot  <= mem_map_pkg::SLOT_GFX;
                        state <= mem_map_pkg::REQ;
                    end
                end
                mem_map_pkg::REQ: begin
                    if (bank_ack) state <= mem_map_pkg::WAIT_RDY;
                end
                mem_map_pkg::WAIT_RDY: begin
                    if (bank_rdy) state <= mem_map_pkg::IDLE;  // Slot drops req on this edge
                end
                default: state <= mem_map_pkg::IDLE;  // Refresh lasts one cycle
            endcase
        end
    end

    a_bank_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({bank_rd, bank_wr}))
        else $error("bank_arbiter: read and write strobes together");

    // The rdy goes to one slot and that slot still holds its request
    a_one_rdy: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant_rdy) && (grant_rdy & ~{gfx_pend, rom_pend, ram_pend}) == 3'b000)
        else $error("bank_arbiter: rdy to more than one slot or to a slot not waiting");

endmodule

`default_nettype wire

/* src/refresh_timer.sv */
// Counts only during blanking (lvbl low); a pending request is kept until the arbiter serves it
`timescale 1ns/100ps
`default_nettype none
`include "mem_map_defines.svh"

module refresh_timer (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  lvbl,
    input  wire  refresh_done,
    output logic refresh_req
);

    localparam int CW = $clog2(`REFRESH_INTERVAL);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt         <= '0;
            refresh_req <= 1'b0;
        end else begin
            if (refresh_done) refresh_req <= 1'b0;
            if (lvbl) begin
                cnt <= '0;  // Active video, hold off
            end else if (cnt == CW'(`REFRESH_INTERVAL - 1)) begin
                cnt         <= '0;
                refresh_req <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    a_done_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        refresh_done |-> refresh_req)
        else $error("refresh_timer: refresh_done without a request");

endmodule

`default_nettype wire

/* src/mem_map.sv */
// Tile fetches only while lvbl is high or on lines 0 and 256 up; bank refresh only in blanking
`timescale 1ns/100ps
`default_nettype none
`include "mem_map_defines.svh"

module mem_map (
    input  wire                clk,
    input  wire                arst_n,
    input  wire                lvbl,
    input  wire [8:0]          vrender,

    // Main CPU work RAM
    input  wire                ram_cs,
    input  wire                main_rnw,
    input  wire [15:0]         main_din,
    input  wire [1:0]          dsn,     // Active low byte enables
    input  wire [14:0]         ram_addr,
    output logic [15:0]        ram_data,
    output logic               ram_ok,

    // Main CPU program ROM
    input  wire                rom_cs,
    input  wire [16:0]         rom_addr,
    output logic [15:0]        rom_data,
    output logic               rom_ok,

    // Tile ROM
    input  wire [16:0]         gfx_addr,
    output logic [31:0]        gfx_data,
    output logic               gfx_ok,

    // SDRAM bank
    input  wire                bank_ack,
    input  wire                bank_rdy,
    input  wire [31:0]         data_read,
    output logic [`MEM_AW-1:0] bank_addr,
    output logic               bank_rd,
    output logic               bank_wr,
    output logic [15:0]        bank_din,
    output logic [1:0]         bank_mask,
    output logic               refresh_en
);

    mem_map_pkg::bank_req_t ram_req;
    mem_map_pkg::bank_req_t rom_req;
    mem_map_pkg::bank_req_t gfx_req;
    logic [2:0]             grant_ack;
    logic [2:0]             grant_rdy;
    logic                   refresh_req;
    logic                   refresh_done;
    logic                   gfx_win;

    assign gfx_win = lvbl || vrender == 9'd0 || vrender[8];

    mem_slot #(.payload_t(logic [15:0]), .AW(15)) ram_slot_i (
        .clk(clk), .arst_n(arst_n),
        .cs(ram_cs), .addr(ram_addr), .offset(`RAM_OFFSET),
        .wen(~main_rnw), .din(main_din), .wrmask(dsn),
        .grant_ack(grant_ack[mem_map_pkg::SLOT_RAM]),
        .grant_rdy(grant_rdy[mem_map_pkg::SLOT_RAM]),
        .data_read(data_read), .dout(ram_data), .ok(ram_ok), .req(ram_req)
    );

    mem_slot #(.payload_t(logic [15:0]), .AW(17)) rom_slot_i (
        .clk(clk), .arst_n(arst_n),
        .cs(rom_cs), .addr(rom_addr), .offset(`ROM_OFFSET),
        .wen(1'b0), .din(16'h0000), .wrmask(2'b11),  // Read only
        .grant_ack(grant_ack[mem_map_pkg::SLOT_ROM]),
        .grant_rdy(grant_rdy[mem_map_pkg::SLOT_ROM]),
        .data_read(data_read), .dout(rom_data), .ok(rom_ok), .req(rom_req)
    );

    mem_slot #(.payload_t(logic [31:0]), .AW(17)) gfx_slot_i (
        .clk(clk), .arst_n(arst_n),
        .cs(gfx_win), .addr(gfx_addr), .offset(`GFX_OFFSET),
        .wen(1'b0), .din(16'h0000), .wrmask(2'b11),
        .grant_ack(grant_ack[mem_map_pkg::SLOT_GFX]),
        .grant_rdy(grant_rdy[mem_map_pkg::SLOT_GFX]),
        .data_read(data_read), .dout(gfx_data), .ok(gfx_ok), .req(gfx_req)
    );

    refresh_timer refresh_timer_i (
        .clk(clk), .arst_n(arst_n), .lvbl(lvbl),
        .refresh_done(refresh_done), .refresh_req(refresh_req)
    );

    bank_arbiter bank_arbiter_i (
        .clk(clk), .arst_n(arst_n),
        .ram_req(ram_req), .rom_req(rom_req), .gfx_req(gfx_req),
        .refresh_req(refresh_req), .bank_ack(bank_ack), .bank_rdy(bank_rdy),
        .grant_ack(grant_ack), .grant_rdy(grant_rdy),
        .refresh_done(refresh_done), .refresh_en(refresh_en),
        .bank_addr(bank_addr), .bank_rd(bank_rd), .bank_wr(bank_wr),
        .bank_din(bank_din), .bank_mask(bank_mask)
    );

endmodule

`default_nettype wire

/* bench/sdram_model.sv */
// Fixed ack and rdy latencies of at least one cycle each; unwritten words read as address ^ 5a5aa5a5
`timescale 1ns/100ps
`default_nettype none
`include "mem_map_defines.svh"

module sdram_model #(
    parameter int ACK_DLY = 2,
    parameter int RDY_DLY = 3
) (
    input  wire               clk,
    input  wire               arst_n,
    input  wire [`MEM_AW-1:0] addr,
    input  wire               rd,
    input  wire               wr,
    input  wire [15:0]        din,
    input  wire [1:0]         mask,    // Active low
    output logic              ack,
    output logic              rdy,
    output logic [31:0]       data_read
);

    logic [15:0] store [logic [`MEM_AW-1:0]];
    logic        busy;                 // Between ack and rdy
    logic [7:0]  cnt;
    logic [31:0] rd_word;
    logic [15:0] wr_word;
    logic        accept;

    // Word as the bank holds it now
    always_comb begin
        rd_word = {10'd0, addr} ^ 32'h5a5a_a5a5;
        if (store.exists(addr)) rd_word[15:0] = store[addr];
        wr_word = {mask[1] ? rd_word[15:8] : din[15:8], mask[0] ? rd_word[7:0] : din[7:0]};
    end

    assign accept = (rd || wr) && !busy && cnt == 8'(ACK_DLY - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack       <= 1'b0;
            rdy       <= 1'b0;
            busy      <= 1'b0;
            cnt       <= '0;
            data_read <= '0;
        end else begin
            ack <= 1'b0;
            rdy <= 1'b0;
            if (accept) begin
                ack       <= 1'b1;
                busy      <= 1'b1;
                cnt       <= '0;
                data_read <= rd_word;
            end else if (busy && cnt == 8'(RDY_DLY - 1)) begin
                rdy  <= 1'b1;  // data_read already valid
                busy <= 1'b0;
                cnt  <= '0;
            end else if (busy || rd || wr) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Writes land when the bank accepts them
    always @(posedge clk) begin
        if (arst_n && accept && wr) store[addr] = wr_word;
    end

endmodule

`default_nettype wire

/* bench/mem_map_tb.sv */
// Bank model latencies are fixed at 2 and 3 cycles; refresh windows scale with REFRESH_INTERVAL
`timescale 1ns/100ps
`default_nettype none
`include "mem_map_defines.svh"

module mem_map_tb;

    localparam int RI       = `REFRESH_INTERVAL;
    localparam int N_TESTS  = 12;
    localparam int OK_LIMIT = 40;  // Cycles per entry

    localparam logic [2:0] OP_RAM   = 3'd0;
    localparam logic [2:0] OP_ROM   = 3'd1;
    localparam logic [2:0] OP_GFX   = 3'd2;
    localparam logic [2:0] OP_BOTH  = 3'd3;  // RAM and ROM in the same cycle
    localparam logic [2:0] OP_NOGFX = 3'd4;  // Tile window closed
    localparam logic [2:0] OP_IDLE  = 3'd5;  // Count refreshes in blanking
    localparam logic [2:0] OP_QUIET = 3'd6;  // No refresh in active video

    typedef struct packed {
        logic [2:0]  op;
        logic [16:0] addr;
        logic        wr;
        logic        hit;      // No bank read allowed
        logic [15:0] data;
        logic [1:0]  mask;
        logic        lvbl;
        logic [8:0]  vrender;
        logic [31:0] exp_val;
        logic [16:0] addr2;    // ROM address of OP_BOTH
        logic [31:0] exp_val2;
    } test_t;

    logic        clk;
    logic        arst_n;
    logic        lvbl;
    logic [8:0]  vrender;
    logic        ram_cs;
    logic        main_rnw;
    logic [15:0] main_din;
    logic [1:0]  dsn;
    logic [14:0] ram_addr;
    logic [15:0] ram_data;
    logic        ram_ok;
    logic        rom_cs;
    logic [16:0] rom_addr;
    logic [15:0] rom_data;
    logic        rom_ok;
    logic [16:0] gfx_addr;
    logic [31:0] gfx_data;
    logic        gfx_ok;
    logic        bank_ack;
    logic        bank_rdy;
    logic [31:0] data_read;
    logic [21:0] bank_addr;
    logic        bank_rd;
    logic        bank_wr;
    logic [15:0] bank_din;
    logic [1:0]  bank_mask;
    logic        refresh_en;

    test_t       tests [N_TESTS];
    int          n_add;
    integer      seed;
    int          errors;
    int          passed;
    int          rd_cnt;
    int          gfx_rd_cnt;
    int          ref_cnt;
    int          gfx_ok_cnt;
    logic        rd_prev;
    logic        wr_prev;
    logic [21:0] last_wr_addr;
    logic [15:0] last_wr_din;
    logic [1:0]  last_wr_mask;
    logic [21:0] rd_log [$];
    logic [15:0] d1;
    logic [15:0] d2;
    logic [15:0] m1;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    mem_map mem_map_i (.*);

    sdram_model #(.ACK_DLY(2), .RDY_DLY(3)) sdram_i (
        .clk(clk), .arst_n(arst_n), .addr(bank_addr), .rd(bank_rd), .wr(bank_wr),
        .din(bank_din), .mask(bank_mask), .ack(bank_ack), .rdy(bank_rdy), .data_read(data_read)
    );

    function automatic logic [31:0] bank_pattern(input logic [21:0] waddr);
        return {10'd0, waddr} ^ 32'h5a5a_a5a5;
    endfunction

    // A low be_n bit takes the new byte
    function automatic logic [15:0] merge_bytes(input logic [15:0] old_w,
                                               input logic [15:0] new_w, input logic [1:0] be_n);
        return {be_n[1] ? old_w[15:8] : new_w[15:8], be_n[0] ? old_w[7:0] : new_w[7:0]};
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic add_test(input logic [2:0] op, input logic [16:0] addr, input logic wr,
                            input logic hit, input logic [15:0] data, input logic [1:0] mask,
                            input logic lv, input logic [8:0] vr, input logic [31:0] exp_val,
                            input logic [16:0] addr2, input logic [31:0] exp_val2);
        tests[n_add] = {op, addr, wr, hit, data, mask, lv, vr, exp_val, addr2, exp_val2};
        n_add++;
    endtask

    // Next falling edge and the bank activity seen there
    task automatic tick();
        @(negedge clk);
        if (bank_rd && !rd_prev) begin
            rd_cnt++;
            rd_log.push_back(bank_addr);
            if (bank_addr >= `GFX_OFFSET) gfx_rd_cnt++;
        end
        if (bank_wr && !wr_prev) begin
            last_wr_addr = bank_addr;
            last_wr_din  = bank_din;
            last_wr_mask = bank_mask;
        end
        if (refresh_en) ref_cnt++;
        if (gfx_ok) gfx_ok_cnt++;
        rd_prev = bank_rd;
        wr_prev = bank_wr;
    endtask

    task automatic wait_ok(input logic [2:0] need, output logic done);
        logic [2:0] seen;
        int         n;
        seen = 3'b000;
        n    = 0;
        while ((seen & need) != need && n < OK_LIMIT) begin
            tick();
            seen = seen | {gfx_ok, rom_ok, ram_ok};
            n++;
        end
        done = (seen & need) == need;
        if (!done) begin
            $display("No ok from clients %b within %0d cycles at %0t ns", need, OK_LIMIT, $time);
            errors++;
        end
    endtask

    task automatic run_test(input int idx, input test_t t);
        int   err0;
        int   rd0;
        int   gfx0;
        int   ref0;
        int   okc0;
        logic done;
        err0         = errors;
        lvbl         = t.lvbl;
        vrender      = t.vrender;
        rd0          = rd_cnt;
        gfx0         = gfx_rd_cnt;
        ref0         = ref_cnt;
        okc0         = gfx_ok_cnt;
        last_wr_addr = '1;  // No bank write seen yet in this entry
        rd_log.delete();
        case (t.op)
            OP_RAM: begin
                ram_addr = t.addr[14:0];
                main_rnw = ~t.wr;
                main_din = t.data;
                dsn      = t.mask;
                ram_cs   = 1'b1;
                wait_ok(3'b001, done);
                if (done && t.wr) begin
                    compare_value("write address", 32'(last_wr_addr),
                                  32'(`RAM_OFFSET + 22'(t.addr)));
                    compare_value("write data", 32'(last_wr_din), 32'(t.data));
                    compare_value("write mask", 32'(last_wr_mask), 32'(t.mask));
                end
                if (done && !t.wr) compare_value("RAM data", 32'(ram_data), t.exp_val);
            end
            OP_ROM: begin
                rom_addr = t.addr;
                rom_cs   = 1'b1;
                wait_ok(3'b010, done);
                if (done) compare_value("ROM data", 32'(rom_data), t.exp_val);
            end
            OP_GFX: begin
                gfx_addr = t.addr;
                wait_ok(3'b100, done);
                if (done) compare_value("GFX data", gfx_data, t.exp_val);
            end
            OP_BOTH: begin
                ram_addr = t.addr[14:0];
                rom_addr = t.addr2;
                ram_cs   = 1'b1;
                rom_cs   = 1'b1;
                wait_ok(3'b011, done);
                if (done) begin
                    compare_value("RAM data", 32'(ram_data), t.exp_val);
                    compare_value("ROM data", 32'(rom_data), t.exp_val2);
                    compare_value("bank reads", 32'(rd_log.size()), 32'd2);
                end
                if (done && rd_log.size() >= 2) begin
                    compare_value("first bank read", 32'(rd_log[0]),
                                  32'(`RAM_OFFSET + 22'(t.addr)));
                    compare_value("second bank read", 32'(rd_log[1]),
                                  32'(`ROM_OFFSET + 22'(t.addr2)));
                end
            end
            OP_NOGFX: begin
                gfx_addr = t.addr;
                repeat (2 * RI) tick();
                compare_value("gfx_ok with window closed", 32'(gfx_ok_cnt - okc0), 32'd0);
                compare_value("GFX reads with window closed", 32'(gfx_rd_cnt - gfx0), 32'd0);
            end
            OP_IDLE: begin
                repeat (4 * RI) tick();
                compare_value("enough refresh pulses", 32'((ref_cnt - ref0) >= t.exp_val),
                              32'd1);
            end
            OP_QUIET: begin
                repeat (RI) tick();  // Let a pending refresh drain
                ref0 = ref_cnt;
                repeat (4 * RI) tick();
                compare_value("refresh pulses in active video", 32'(ref_cnt - ref0), t.exp_val);
            end
            default: ;
        endcase
        if (t.hit) compare_value("bank reads on a hit", 32'(rd_cnt - rd0), 32'd0);
        ram_cs   = 1'b0;
        rom_cs   = 1'b0;
        main_rnw = 1'b1;
        dsn      = 2'b11;
        tick();
        if (errors == err0) passed++;
        $display("test %0d op %0d: %s", idx, t.op, errors == err0 ? "passed" : "failed");
    endtask

    initial begin
        repeat (N_TESTS * 60) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished", N_TESTS * 60);
        $display("Something failed");
        $finish;
    end

    initial begin
        arst_n     = 1'b0;
        lvbl       = 1'b1;
        vrender    = 9'd100;
        ram_cs     = 1'b0;
        main_rnw   = 1'b1;
        main_din   = 16'h0000;
        dsn        = 2'b11;
        ram_addr   = '0;
        rom_cs     = 1'b0;
        rom_addr   = '0;
        gfx_addr   = '0;
        n_add      = 0;
        errors     = 0;
        passed     = 0;
        rd_cnt     = 0;
        gfx_rd_cnt = 0;
        ref_cnt    = 0;
        gfx_ok_cnt = 0;
        rd_prev    = 1'b0;
        wr_prev    = 1'b0;
        seed       = 32'hf6e6_f05b;
        d1 = 16'($random(seed));
        d2 = 16'($random(seed));
        m1 = merge_bytes(16'(bank_pattern(`RAM_OFFSET + 22'h0123)), d1, 2'b10);

        // op, addr, wr, hit, data, mask, lvbl, vrender, expected, addr2, expected2
        add_test(OP_ROM, 17'h1_2345, 0, 0, 0, 2'b11, 1, 9'd100,
                 {16'h0, 16'(bank_pattern(`ROM_OFFSET + 22'h1_2345))}, 0, 0);
        add_test(OP_ROM, 17'h1_2345, 0, 1, 0, 2'b11, 1, 9'd100,
                 {16'h0, 16'(bank_pattern(`ROM_OFFSET + 22'h1_2345))}, 0, 0);
        add_test(OP_RAM, 17'h0123, 1, 0, d1, 2'b10, 1, 9'd100, 0, 0, 0);
        add_test(OP_RAM, 17'h0123, 0, 0, 0, 2'b11, 1, 9'd100, {16'h0, m1}, 0, 0);
        add_test(OP_RAM, 17'h0123, 1, 0, d2, 2'b01, 1, 9'd100, 0, 0, 0);
        add_test(OP_RAM, 17'h0123, 0, 1, 0, 2'b11, 1, 9'd100,
                 {16'h0, merge_bytes(m1, d2, 2'b01)}, 0, 0);
        add_test(OP_GFX, 17'h0_0abc, 0, 0, 0, 2'b11, 1, 9'd100,
                 bank_pattern(`GFX_OFFSET + 22'h0abc), 0, 0);
        add_test(OP_NOGFX, 17'h0_1111, 0, 0, 0, 2'b11, 0, 9'd100, 0, 0, 0);
        add_test(OP_GFX, 17'h0_1111, 0, 0, 0, 2'b11, 0, 9'd0,
                 bank_pattern(`GFX_OFFSET + 22'h1111), 0, 0);
        add_test(OP_GFX, 17'h0_2222, 0, 0, 0, 2'b11, 0, 9'd300,
                 bank_pattern(`GFX_OFFSET + 22'h2222), 0, 0);
        add_test(OP_BOTH, 17'h0456, 0, 0, 0, 2'b11, 1, 9'd100,
                 {16'h0, 16'(bank_pattern(`RAM_OFFSET + 22'h0456))}, 17'h0_0777,
                 {16'h0, 16'(bank_pattern(`ROM_OFFSET + 22'h0777))});
        add_test(OP_IDLE, 0, 0, 0, 0, 2'b11, 0, 9'd100, 32'd3, 0, 0);
        add_test(OP_QUIET, 0, 0, 0, 0, 2'b11, 1, 9'd100, 32'd0, 0, 0);

        repeat (5) tick();
        arst_n = 1'b1;
        repeat (RI) tick();  // Tile slot settles on its first word
        for (int i = 0; i < N_TESTS; i++) run_test(i, tests[i]);

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 N_TESTS, passed, N_TESTS - passed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/mem_map_pkg.sv
src/mem_slot.sv
src/bank_arbiter.sv
src/refresh_timer.sv
src/mem_map.sv
bench/sdram_model.sv
bench/mem_map_tb.sv

/* run.sh */
#!/bin/sh
# Builds with Verilator and runs; passes only when the testbench reports success
verilator --binary --timing --assert --top-module mem_map_tb -f vlog.f -o mem_map_sim \
    && ./obj_dir/mem_map_sim | tee /dev/stderr | grep "Everything OK" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
